// ==== dcache_defines.svh ====
`ifndef DCACHE_DEFINES_SVH
`define DCACHE_DEFINES_SVH

// cpu side widths
`define DC_ADDR_W      32
`define DC_XLEN        64

// one line is four words
`define DC_LINE_W      256
`define DC_BEATS       4

// 64 sets, 2 ways
`define DC_SETS        64
`define DC_INDEX_W     6

// address split: tag | index | offset
`define DC_OFFSET_W    5
`define DC_TAG_W       21

// bytes per word, also the store mask width
`define DC_WORD_BYTES  8

`endif

// ==== dcache_pkg.sv ====
`include "dcache_defines.svh"

package dcache_pkg;

  // controller states
  typedef enum logic [2:0] {
    idle      = 3'd0,
    compare   = 3'd1,
    writeBack = 3'd2,
    refillReq = 3'd3,
    refill    = 3'd4,
    replace   = 3'd5
  } cacheState_e;

  typedef enum logic {
    opLoad  = 1'b0,
    opStore = 1'b1
  } memOp_e;

  // wdata is right aligned, shifted into place inside the cache
  typedef struct packed {
    memOp_e                     op;
    logic [`DC_ADDR_W-1:0]      addr;
    logic [`DC_XLEN-1:0]        wdata;
    logic [`DC_WORD_BYTES-1:0]  wmask;
  } cpuReq_t;

  // dirty victim going out, addr is line aligned
  typedef struct packed {
    logic [`DC_ADDR_W-1:0]  addr;
    logic [`DC_LINE_W-1:0]  line;
  } memWrReq_t;

  // replace strobe into tag store and data array
  typedef struct packed {
    logic en;
    logic way;
    logic dirty;
  } lineFill_t;

endpackage

// ==== refillBuffer.sv ====
`timescale 1ns/10ps
`include "dcache_defines.svh"

module refillBuffer (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   refillActive_i,
  input  logic [`DC_XLEN-1:0]    memRdData_i,
  input  logic                   memRdDataValid_i,
  output logic [`DC_LINE_W-1:0]  line_o
);

  localparam int cntW = $clog2(`DC_BEATS);

  logic [cntW-1:0]        beatCnt;
  logic [`DC_LINE_W-1:0]  lineBuf;

  // beat k goes to word k, counter restarts for every refill
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      beatCnt <= '0;
    end else if (!refillActive_i) begin
      beatCnt <= '0;
    end else if (memRdDataValid_i) begin
      beatCnt <= beatCnt + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (refillActive_i && memRdDataValid_i) begin
      lineBuf[beatCnt*`DC_XLEN +: `DC_XLEN] <= memRdData_i;
    end
  end

  assign line_o = lineBuf;

endmodule

// ==== dataArray.sv ====
`timescale 1ns/10ps
`include "dcache_defines.svh"

module dataArray (
  input  logic                   clk,
  input  dcache_pkg::cpuReq_t    curReq_i,
  input  logic                   storeEn_i,
  input  logic                   hitWay_i,
  input  dcache_pkg::lineFill_t  fill_i,
  input  logic [`DC_LINE_W-1:0]  fillLine_i,
  input  logic                   victimWay_i,
  output logic [`DC_XLEN-1:0]    rdata_o,
  output logic [`DC_LINE_W-1:0]  victimLine_o
);

  localparam int byteBits = $clog2(`DC_WORD_BYTES);
  localparam int wordBits = $clog2(`DC_XLEN);

  logic [`DC_LINE_W-1:0]            lineMem [2][`DC_SETS];
  logic [`DC_INDEX_W-1:0]           index;
  logic [`DC_OFFSET_W-byteBits-1:0] wordSel;
  logic [byteBits-1:0]              byteOff;
  logic [`DC_XLEN-1:0]              storeWord;
  logic [`DC_WORD_BYTES-1:0]        storeMask;
  logic [`DC_XLEN-1:0]              bitMask;
  logic [`DC_LINE_W-1:0]            lineData;
  logic [`DC_LINE_W-1:0]            lineMask;
  logic [`DC_LINE_W-1:0]            hitLine;
  logic                             isStore;

  function automatic logic [`DC_LINE_W-1:0] mergeStore(input logic [`DC_LINE_W-1:0] base,
                                                       input logic [`DC_LINE_W-1:0] data,
                                                       input logic [`DC_LINE_W-1:0] mask);
    return (base & ~mask) | (data & mask);
  endfunction

  assign index   = curReq_i.addr[`DC_OFFSET_W +: `DC_INDEX_W];
  assign wordSel = curReq_i.addr[`DC_OFFSET_W-1:byteBits];
  assign byteOff = curReq_i.addr[byteBits-1:0];
  assign isStore = (curReq_i.op == dcache_pkg::opStore);

  // right aligned store data moves up to its byte lane
  assign storeWord = curReq_i.wdata << {byteOff, 3'b000};
  assign storeMask = curReq_i.wmask << byteOff;

  always_comb begin
    for (int b = 0; b < `DC_WORD_BYTES; b++) begin
      bitMask[b*8 +: 8] = {8{storeMask[b]}};
    end
  end

  // place the word into its slot of the line
  assign lineData = {(`DC_LINE_W/`DC_XLEN){storeWord}};
  assign lineMask = {{(`DC_LINE_W-`DC_XLEN){1'b0}}, bitMask} << {wordSel, {wordBits{1'b0}}};

  assign hitLine      = lineMem[hitWay_i][index];
  assign rdata_o      = hitLine[wordSel*`DC_XLEN +: `DC_XLEN];
  assign victimLine_o = lineMem[victimWay_i][index];

  always_ff @(posedge clk) begin
    if (fill_i.en) begin
      // a store miss lands on top of the refilled line
      lineMem[fill_i.way][index] <= isStore ? mergeStore(fillLine_i, lineData, lineMask)
                                            : fillLine_i;
    end else if (storeEn_i) begin
      lineMem[hitWay_i][index] <= mergeStore(hitLine, lineData, lineMask);
    end
  end

endmodule

// ==== tagStore.sv ====
`timescale 1ns/10ps
`include "dcache_defines.svh"

module tagStore (
  input  logic                   clk,
  input  logic                   rst_n,
  input  dcache_pkg::cpuReq_t    curReq_i,
  input  logic                   storeEn_i,
  input  dcache_pkg::lineFill_t  fill_i,
  output logic                   hit_o,
  output logic                   hitWay_o,
  output logic                   victimWay_o,
  output logic                   victimDirty_o,
  output logic [`DC_ADDR_W-1:0]  victimAddr_o
);

  logic [`DC_TAG_W-1:0]      tagMem [2][`DC_SETS];
  logic [1:0][`DC_SETS-1:0]  validBits;
  logic [1:0][`DC_SETS-1:0]  dirtyBits;
  logic                      victimSel;
  logic [`DC_INDEX_W-1:0]    index;
  logic [`DC_TAG_W-1:0]      reqTag;
  logic [1:0]                wayHit;

  assign index  = curReq_i.addr[`DC_OFFSET_W +: `DC_INDEX_W];
  assign reqTag = curReq_i.addr[`DC_ADDR_W-1 -: `DC_TAG_W];

  always_comb begin
    for (int w = 0; w < 2; w++) begin
      wayHit[w] = validBits[w][index] && (tagMem[w][index] == reqTag);
    end
  end

  assign hit_o    = |wayHit;
  assign hitWay_o = wayHit[1];

  // victim is whichever way the toggle points at
  assign victimWay_o   = victimSel;
  assign victimDirty_o = validBits[victimSel][index] && dirtyBits[victimSel][index];
  assign victimAddr_o  = {tagMem[victimSel][index], index, {`DC_OFFSET_W{1'b0}}};

  always_ff @(posedge clk) begin
    if (fill_i.en) begin
      tagMem[fill_i.way][index] <= reqTag;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      validBits <= '0;
      dirtyBits <= '0;
      victimSel <= 1'b0;
    end else if (fill_i.en) begin
      validBits[fill_i.way][index] <= 1'b1;
      dirtyBits[fill_i.way][index] <= fill_i.dirty;
      // flip after every replace
      victimSel <= ~victimSel;
    end else if (storeEn_i) begin
      dirtyBits[hitWay_o][index] <= 1'b1;
    end
  end

endmodule

// ==== cacheCtrl.sv ====
`timescale 1ns/10ps
`include "dcache_defines.svh"

module cacheCtrl (
  input  logic                   clk,
  input  logic                   rst_n,
  input  dcache_pkg::cpuReq_t    cpuReq_i,
  input  logic                   reqValid_i,
  output logic                   reqReady_o,
  output logic                   respValid_o,
  input  logic                   hit_i,
  input  logic                   victimDirty_i,
  input  logic [`DC_ADDR_W-1:0]  victimAddr_i,
  input  logic                   memRdReady_i,
  input  logic                   memRdLast_i,
  input  logic                   memWrReady_i,
  output logic                   memRdValid_o,
  output logic [`DC_ADDR_W-1:0]  memRdAddr_o,
  output logic                   memWrValid_o,
  output dcache_pkg::cpuReq_t    curReq_o,
  output logic                   storeEn_o,
  output dcache_pkg::lineFill_t  fill_o,
  output logic                   refillActive_o,
  input  logic                   victimWay_i
);

  dcache_pkg::cacheState_e  state;
  dcache_pkg::cacheState_e  nextState;
  dcache_pkg::cpuReq_t      curReq;
  logic                     inCompare;
  logic                     accept;
  logic                     isStore;

  assign inCompare = (state == dcache_pkg::compare);
  assign isStore   = (curReq.op == dcache_pkg::opStore);

  // new request only while idle or while the current one hits
  assign reqReady_o  = (state == dcache_pkg::idle) || (inCompare && hit_i);
  assign accept      = reqValid_i && reqReady_o;
  assign respValid_o = inCompare && hit_i;
  assign storeEn_o   = respValid_o && isStore;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= dcache_pkg::idle;
    end else begin
      state <= nextState;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      curReq <= '0;
    end else if (accept) begin
      curReq <= cpuReq_i;
    end
  end

  always_comb begin
    nextState = state;
    case (state)
      dcache_pkg::idle: begin
        if (reqValid_i) begin
          nextState = dcache_pkg::compare;
        end
      end
      dcache_pkg::compare: begin
        if (hit_i) begin
          // back to back hits stay in compare
          nextState = reqValid_i ? dcache_pkg::compare : dcache_pkg::idle;
        end else if (victimDirty_i) begin
          nextState = dcache_pkg::writeBack;
        end else begin
          nextState = dcache_pkg::refillReq;
        end
      end
      dcache_pkg::writeBack: begin
        if (memWrReady_i) begin
          nextState = dcache_pkg::refillReq;
        end
      end
      dcache_pkg::refillReq: begin
        if (memRdReady_i) begin
          nextState = dcache_pkg::refill;
        end
      end
      dcache_pkg::refill: begin
        if (memRdLast_i) begin
          nextState = dcache_pkg::replace;
        end
      end
      dcache_pkg::replace: begin
        // rerun the compare, which now hits
        nextState = dcache_pkg::compare;
      end
      default: begin
        nextState = dcache_pkg::idle;
      end
    endcase
  end

  // bus requests are decoded straight from the state register
  assign memWrValid_o   = (state == dcache_pkg::writeBack);
  assign memRdValid_o   = (state == dcache_pkg::refillReq);
  assign refillActive_o = (state == dcache_pkg::refill);
  assign memRdAddr_o    = {curReq.addr[`DC_ADDR_W-1:`DC_OFFSET_W], {`DC_OFFSET_W{1'b0}}};

  // a store miss leaves the refilled line dirty
  assign fill_o = '{en: (state == dcache_pkg::replace), way: victimWay_i, dirty: isStore};

  assign curReq_o = curReq;

endmodule

// ==== dcacheTop.sv ====
`timescale 1ns/10ps
`include "dcache_defines.svh"

module dcacheTop (
  input  logic                   clk,
  input  logic                   rst_n,
  input  dcache_pkg::cpuReq_t    cpuReq_i,
  input  logic                   reqValid_i,
  output logic                   reqReady_o,
  output logic                   respValid_o,
  output logic [`DC_XLEN-1:0]    rdata_o,
  output logic                   memRdValid_o,
  input  logic                   memRdReady_i,
  output logic [`DC_ADDR_W-1:0]  memRdAddr_o,
  input  logic [`DC_XLEN-1:0]    memRdData_i,
  input  logic                   memRdDataValid_i,
  input  logic                   memRdLast_i,
  output logic                   memWrValid_o,
  input  logic                   memWrReady_i,
  output dcache_pkg::memWrReq_t  memWrReq_o
);

  dcache_pkg::cpuReq_t    curReq;
  dcache_pkg::lineFill_t  fill;
  logic                   storeEn;
  logic                   refillActive;
  logic                   hit;
  logic                   hitWay;
  logic                   victimWay;
  logic                   victimDirty;
  logic [`DC_ADDR_W-1:0]  victimAddr;
  logic [`DC_LINE_W-1:0]  fillLine;
  logic [`DC_LINE_W-1:0]  victimLine;

  // write-back carries the victim line at its own address
  assign memWrReq_o = '{addr: victimAddr, line: victimLine};

  cacheCtrl i_cacheCtrl (
    .clk(clk), .rst_n(rst_n), .cpuReq_i(cpuReq_i), .reqValid_i(reqValid_i),
    .reqReady_o(reqReady_o), .respValid_o(respValid_o), .hit_i(hit),
    .victimDirty_i(victimDirty), .victimAddr_i(victimAddr), .memRdReady_i(memRdReady_i),
    .memRdLast_i(memRdLast_i), .memWrReady_i(memWrReady_i), .memRdValid_o(memRdValid_o),
    .memRdAddr_o(memRdAddr_o), .memWrValid_o(memWrValid_o), .curReq_o(curReq),
    .storeEn_o(storeEn), .fill_o(fill), .refillActive_o(refillActive),
    .victimWay_i(victimWay)
  );

  tagStore i_tagStore (
    .clk(clk), .rst_n(rst_n), .curReq_i(curReq), .storeEn_i(storeEn), .fill_i(fill),
    .hit_o(hit), .hitWay_o(hitWay), .victimWay_o(victimWay),
    .victimDirty_o(victimDirty), .victimAddr_o(victimAddr)
  );

  dataArray i_dataArray (
    .clk(clk), .curReq_i(curReq), .storeEn_i(storeEn), .hitWay_i(hitWay), .fill_i(fill),
    .fillLine_i(fillLine), .victimWay_i(victimWay), .rdata_o(rdata_o),
    .victimLine_o(victimLine)
  );

  refillBuffer i_refillBuffer (
    .clk(clk), .rst_n(rst_n), .refillActive_i(refillActive), .memRdData_i(memRdData_i),
    .memRdDataValid_i(memRdDataValid_i), .line_o(fillLine)
  );

endmodule

// ==== dcache_chk.sv ====
`timescale 1ns/10ps

module dcache_chk (
  input logic                   clk,
  input logic                   rst_n,
  input logic                   reqValid_i,
  input logic                   reqReady_i,
  input logic                   respValid_i,
  input logic                   memRdValid_i,
  input logic                   memRdReady_i,
  input logic [31:0]            memRdAddr_i,
  input logic                   memWrValid_i,
  input logic                   memWrReady_i,
  input dcache_pkg::memWrReq_t  memWrReq_i
);

  logic pending;

  // one request in flight between acceptance and its response
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pending <= 1'b0;
    end else if (reqValid_i && reqReady_i) begin
      pending <= 1'b1;
    end else if (respValid_i) begin
      pending <= 1'b0;
    end
  end

  rdHold: assert property (@(posedge clk) disable iff (!rst_n)
      memRdValid_i && !memRdReady_i |=> memRdValid_i && $stable(memRdAddr_i))
    else $error("read request dropped or changed before ready");

  wrHold: assert property (@(posedge clk) disable iff (!rst_n)
      memWrValid_i && !memWrReady_i |=> memWrValid_i && $stable(memWrReq_i))
    else $error("write-back request dropped or changed before ready");

  respNeedsReq: assert property (@(posedge clk) disable iff (!rst_n)
      respValid_i |-> pending)
    else $error("response without an accepted request");

  busExclusive: assert property (@(posedge clk) disable iff (!rst_n)
      !(memRdValid_i && memWrValid_i))
    else $error("read and write-back requested together");

endmodule

bind dcacheTop dcache_chk i_dcacheChk (
  .clk(clk), .rst_n(rst_n), .reqValid_i(reqValid_i), .reqReady_i(reqReady_o),
  .respValid_i(respValid_o), .memRdValid_i(memRdValid_o), .memRdReady_i(memRdReady_i),
  .memRdAddr_i(memRdAddr_o), .memWrValid_i(memWrValid_o), .memWrReady_i(memWrReady_i),
  .memWrReq_i(memWrReq_o)
);

// ==== tb_clkGen.sv ====
`timescale 1ns/10ps

module tb_clkGen (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o;
  end

  // hold reset low for three rising edges
  initial begin
    rst_n_o = 1'b0;
    repeat (3) @(posedge clk_o);
    #1 rst_n_o = 1'b1;
  end

endmodule

// ==== tb_dcache.sv ====
`timescale 1ns/10ps
`include "dcache_defines.svh"

module tb_dcache;

  logic clk;
  logic rst_n;
  dcache_pkg::cpuReq_t cpuReq;
  logic reqValid, reqReady, respValid, memRdValid, memRdReady, memRdDataValid;
  logic memRdLast, memWrValid, memWrReady;
  logic [63:0] rdata, memRdData;
  logic [31:0] memRdAddr;
  dcache_pkg::memWrReq_t memWrReq;

  logic [63:0] refMem [logic [31:0]];
  logic [63:0] busMem [logic [31:0]];
  logic [63:0] expQ[$];
  bit          loadQ[$];
  int seed = 62763;
  int errCount = 0;
  int rdCount = 0;
  int wrCount = 0;
  int lastLat;
  bit timedOut = 0;
  logic [31:0] lastRdAddr;
  logic [31:0] lastWrAddr;

  tb_clkGen i_clkGen (.clk_o(clk), .rst_n_o(rst_n));

  dcacheTop i_dcacheTop (
    .clk(clk), .rst_n(rst_n), .cpuReq_i(cpuReq), .reqValid_i(reqValid),
    .reqReady_o(reqReady), .respValid_o(respValid), .rdata_o(rdata),
    .memRdValid_o(memRdValid), .memRdReady_i(memRdReady), .memRdAddr_o(memRdAddr),
    .memRdData_i(memRdData), .memRdDataValid_i(memRdDataValid), .memRdLast_i(memRdLast),
    .memWrValid_o(memWrValid), .memWrReady_i(memWrReady), .memWrReq_o(memWrReq)
  );

  // fill pattern over the whole word address
  function automatic logic [63:0] hashWord(input logic [31:0] a);
    return {a ^ 32'h9e3779b9, ~a};
  endfunction

  function automatic logic [63:0] busWord(input logic [31:0] a);
    logic [31:0] w;
    w = {a[31:3], 3'b000};
    return busMem.exists(w) ? busMem[w] : hashWord(w);
  endfunction

  // expected word as seen by the cpu after all earlier stores
  function automatic logic [63:0] refWord(input logic [31:0] a);
    logic [31:0] w;
    w = {a[31:3], 3'b000};
    return refMem.exists(w) ? refMem[w] : hashWord(w);
  endfunction

  task automatic refStore(input logic [31:0] a, input logic [63:0] d, input logic [7:0] m);
    logic [63:0] word;
    int off;
    word = refWord(a);
    off = a[2:0];
    for (int b = off; b < 8; b++) begin
      if (m[b-off]) begin
        word[b*8 +: 8] = d[(b-off)*8 +: 8];
      end
    end
    refMem[{a[31:3], 3'b000}] = word;
  endtask

  task automatic noteTimeout(input string what);
    $display("timeout at %0t while waiting for %s", $time, what);
    errCount++;
    timedOut = 1;
  endtask

  // issue one request and wait for its response
  // lastLat counts cycles after acceptance
  task automatic doReq(input bit store, input logic [31:0] a, input logic [63:0] d,
                       input logic [7:0] m);
    int n;
    bit done;
    if (timedOut) return;
    @(posedge clk);
    #1;
    cpuReq = '{op: store ? dcache_pkg::opStore : dcache_pkg::opLoad,
               addr: a, wdata: d, wmask: m};
    reqValid = 1'b1;
    n = 0;
    done = 0;
    while (!done) begin
      @(negedge clk);
      done = reqReady;
      n++;
      if (!done && n > 100) begin
        noteTimeout("request acceptance");
        return;
      end
    end
    expQ.push_back(refWord(a));
    loadQ.push_back(!store);
    if (store) refStore(a, d, m);
    @(posedge clk);
    #1 reqValid = 1'b0;
    lastLat = 0;
    done = 0;
    while (!done) begin
      @(negedge clk);
      lastLat++;
      done = respValid;
      if (!done && lastLat > 300) begin
        noteTimeout("response");
        return;
      end
    end
  endtask

  // compare process
  always @(negedge clk) begin
    logic [63:0] exp;
    bit isLoad;
    if (rst_n && respValid && expQ.size() > 0) begin
      exp = expQ.pop_front();
      isLoad = loadQ.pop_front();
      if (isLoad) begin
        assert (rdata === exp)
          else begin
            $display("[FAIL] %0t rdata_o got %h expected %h", $time, rdata, exp);
            errCount++;
          end
      end
    end
  end

  // memory model polling the bus requests every cycle
  initial begin
    int d;
    logic [31:0] a;
    forever begin
      @(negedge clk);
      if (memWrValid || memRdValid) begin
        d = $unsigned($random(seed)) % 4;
        repeat (d) @(posedge clk);
        @(posedge clk);
        #1;
        if (memWrValid) begin
          memWrReady = 1'b1;
          @(posedge clk);
          #1 memWrReady = 1'b0;
          wrCount++;
          lastWrAddr = memWrReq.addr;
          for (int k = 0; k < 4; k++) begin
            a = memWrReq.addr + k * 8;
            assert (memWrReq.line[k*64 +: 64] === refWord(a))
              else begin
                $display("[FAIL] %0t memWrReq_o.line word %0d got %h expected %h", $time, k,
                         memWrReq.line[k*64 +: 64], refWord(a));
                errCount++;
              end
            busMem[a] = memWrReq.line[k*64 +: 64];
          end
        end else begin
          memRdReady = 1'b1;
          lastRdAddr = memRdAddr;
          rdCount++;
          @(posedge clk);
          #1 memRdReady = 1'b0;
          for (int k = 0; k < 4; k++) begin
            memRdDataValid = 1'b1;
            memRdData = busWord(lastRdAddr + k * 8);
            memRdLast = (k == 3);
            @(posedge clk);
            #1;
          end
          memRdDataValid = 1'b0;
          memRdLast = 1'b0;
        end
      end
    end
  end

  task automatic report(input string name, input int errsBefore);
    $display("%s: %s", name, (errCount == errsBefore) ? "ok" : "FAILED");
  endtask

  initial begin
    int e, r0, w0, tests, n;
    logic [31:0] a;
    cpuReq = '0;
    reqValid = 0;
    memRdReady = 0;
    memRdData = '0;
    memRdDataValid = 0;
    memRdLast = 0;
    memWrReady = 0;
    tests = 0;
    n = 0;
    while (rst_n !== 1'b1 && n < 20) begin
      @(negedge clk);
      n++;
    end
    if (rst_n !== 1'b1) begin
      noteTimeout("reset release");
    end

    e = errCount;
    assert (reqReady === 1'b1 && respValid === 1'b0 && memRdValid === 1'b0 &&
            memWrValid === 1'b0)
      else begin
        $display("outputs after reset are not in their idle values");
        errCount++;
      end
    report("reset values", e);
    tests++;

    e = errCount;
    r0 = rdCount;
    doReq(0, 32'h0000_0112, '0, '0);
    assert (rdCount == r0 + 1 && lastRdAddr == 32'h0000_0100)
      else begin
        $display("[FAIL] %0t memRdAddr_o got %h expected %h, reads %0d", $time,
                 lastRdAddr, 32'h0000_0100, rdCount - r0);
        errCount++;
      end
    report("cold load", e);
    tests++;

    e = errCount;
    r0 = rdCount;
    doReq(0, 32'h0000_0108, '0, '0);
    assert (lastLat == 1 && rdCount == r0)
      else begin
        $display("hit took %0d cycles with %0d bus reads", lastLat, rdCount - r0);
        errCount++;
      end
    report("load hit", e);
    tests++;

    e = errCount;
    doReq(1, 32'h0000_0113, 64'h0000_0000_00a5_5a3c, 8'b0000_0101);
    doReq(0, 32'h0000_0110, '0, '0);
    report("partial store", e);
    tests++;

    e = errCount;
    w0 = wrCount;
    for (int t = 0; t < 3; t++) begin
      doReq(1, 32'h0000_1008 + t * 32'h800, 64'h1111_2222_3333_0000 + t, 8'hff);
    end
    // the third store evicts the first dirty line
    assert (wrCount == w0 + 1 && lastWrAddr == 32'h0000_1000)
      else begin
        $display("[FAIL] %0t memWrReq_o.addr got %h expected %h, write-backs %0d", $time,
                 lastWrAddr, 32'h0000_1000, wrCount - w0);
        errCount++;
      end
    for (int t = 0; t < 3; t++) begin
      doReq(0, 32'h0000_1008 + t * 32'h800, '0, '0);
    end
    report("eviction", e);
    tests++;

    e = errCount;
    for (int t = 0; t < 200; t++) begin
      a = {$unsigned($random(seed))} % 4;
      a = (a << 11) | ((16 + {$unsigned($random(seed))} % 4) << 5) | ($random(seed) & 31);
      doReq($random(seed) & 1, a, {$random(seed), $random(seed)}, $random(seed));
    end
    report("random traffic", e);
    tests++;

    $display("tests run %0d, errors %0d", tests, errCount);
    if (errCount == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// ==== filelist.f ====
+incdir+.
dcache_pkg.sv
refillBuffer.sv
dataArray.sv
tagStore.sv
cacheCtrl.sv
dcacheTop.sv
dcache_chk.sv
tb_clkGen.sv
tb_dcache.sv
